//--- all.f
cpu_subsystem_pkg.sv
bus_slot_timer.sv
master_addr_decoder.sv
sub_addr_decoder.sv
shared_bus_mux.sv
cpu_subsystem.sv
cpu_subsystem_tb.sv

//--- bus_slot_timer.sv
`default_nettype none
`timescale 1ns/10ps

module bus_slot_timer #(
	parameter int SLOT_CYCLES = 4
) (
	input  logic clk_6m,
	input  logic rst,
	input  logic vblank,
	output logic slot_master,
	output logic slot_start,
	output logic frame_start
);

	localparam int CNT_W = $clog2(SLOT_CYCLES + 1);

	logic [CNT_W-1:0] slot_cnt;
	logic             vblank_d;

	// Master owns the first slot after reset
	always_ff @(posedge clk_6m) begin
		if (rst) begin
			slot_cnt    <= '0;
			slot_master <= 1'b1;
		end else if (slot_cnt == CNT_W'(SLOT_CYCLES - 1)) begin
			slot_cnt    <= '0;
			slot_master <= ~slot_master;
		end else begin
			slot_cnt <= slot_cnt + 1'b1;
		end
	end

	assign slot_start = (slot_cnt == '0);

	// Rising vblank gives a pulse one cycle later
	always_ff @(posedge clk_6m) begin
		if (rst) begin
			vblank_d    <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			vblank_d    <= vblank;
			frame_start <= vblank & ~vblank_d;
		end
	end

endmodule

`default_nettype wire

//--- cpu_subsystem.sv
`default_nettype none
`timescale 1ns/10ps

module cpu_subsystem #(
	parameter int SLOT_CYCLES     = 4,
	parameter int WATCHDOG_FRAMES = 3
) (
	input  logic                       clk_6m,
	input  logic                       rst,
	input  logic                       vblank,
	input  cpu_subsystem_pkg::cpu_req_t m_cpu,
	output cpu_subsystem_pkg::cpu_rsp_t m_rsp,
	output cpu_subsystem_pkg::rom_req_t m_rom,
	input  logic [7:0]                 m_rom_data,
	input  cpu_subsystem_pkg::cpu_req_t s_cpu,
	output cpu_subsystem_pkg::cpu_rsp_t s_rsp,
	output cpu_subsystem_pkg::rom_req_t s_rom,
	input  logic [7:0]                 s_rom_data,
	output cpu_subsystem_pkg::vbus_t    vbus,
	input  logic [7:0]                 vbus_rdata,
	output logic                       m_irq,
	output logic                       s_irq,
	output logic                       cpu_reset
);

	import cpu_subsystem_pkg::*;

	logic        slot_master;
	logic        slot_start;
	logic        frame_start;
	logic        wdog_reset;
	shared_req_t m_sh_req;
	shared_rsp_t m_sh_rsp;
	shared_req_t s_sh_req;
	shared_rsp_t s_sh_rsp;

	// Watchdog pulls both CPUs into reset
	assign cpu_reset = rst | wdog_reset;

	////////////////////
	// Timing

	bus_slot_timer #(
		.SLOT_CYCLES(SLOT_CYCLES)
	) u_timer (
		.clk_6m(clk_6m),
		.rst(rst),
		.vblank(vblank),
		.slot_master(slot_master),
		.slot_start(slot_start),
		.frame_start(frame_start)
	);

	////////////////////
	// CPU ports

	master_addr_decoder #(
		.WATCHDOG_FRAMES(WATCHDOG_FRAMES)
	) u_master_dec (
		.clk_6m(clk_6m),
		.rst(rst),
		.frame_start(frame_start),
		.cpu(m_cpu),
		.rsp(m_rsp),
		.rom(m_rom),
		.rom_data(m_rom_data),
		.sh_req(m_sh_req),
		.sh_rsp(m_sh_rsp),
		.irq(m_irq),
		.wdog_reset(wdog_reset)
	);

	sub_addr_decoder u_sub_dec (
		.clk_6m(clk_6m),
		.rst(rst),
		.cpu_reset(cpu_reset),
		.frame_start(frame_start),
		.cpu(s_cpu),
		.rsp(s_rsp),
		.rom(s_rom),
		.rom_data(s_rom_data),
		.sh_req(s_sh_req),
		.sh_rsp(s_sh_rsp),
		.irq(s_irq)
	);

	// Shared video bus in alternate slots
	shared_bus_mux u_mux (
		.clk_6m(clk_6m),
		.rst(rst),
		.slot_master(slot_master),
		.slot_start(slot_start),
		.m_req(m_sh_req),
		.m_rsp(m_sh_rsp),
		.s_req(s_sh_req),
		.s_rsp(s_sh_rsp),
		.vbus(vbus),
		.vbus_rdata(vbus_rdata)
	);

endmodule

`default_nettype wire

//--- cpu_subsystem_pkg.sv
`default_nettype none

package cpu_subsystem_pkg;

	////////////////////
	// Address map

	localparam logic [15:0] SCROLL0_BASE   = 16'h0000;
	localparam logic [15:0] SCROLL1_BASE   = 16'h2000;
	localparam logic [15:0] OBJECT_BASE    = 16'h4000;
	localparam logic [15:0] LATCH0_ADDR    = 16'h6000;
	localparam logic [15:0] LATCH1_ADDR    = 16'h6001;
	localparam logic [15:0] BACKCOLOR_ADDR = 16'h6002;
	localparam logic [15:0] WDOG_ADDR      = 16'h7000;
	localparam logic [15:0] BANK_ADDR      = 16'h7000;
	localparam logic [15:0] IRQACK_ADDR    = 16'h7800;
	localparam logic [15:0] ROM_BASE       = 16'h8000;

	localparam logic [7:0] UNMAPPED_DATA = 8'hFF;
	localparam int         RESET_PULSE   = 16;

	////////////////////
	// Enums

	typedef enum logic [2:0] {
		T_SCROLL0   = 3'd0,
		T_SCROLL1   = 3'd1,
		T_OBJECT    = 3'd2,
		T_LATCH0    = 3'd3,
		T_LATCH1    = 3'd4,
		T_BACKCOLOR = 3'd5
	} vbus_target_e;

	typedef enum logic [1:0] {
		S_IDLE   = 2'd0,
		S_ROM    = 2'd1,
		S_SHARED = 2'd2,
		S_ACK    = 2'd3
	} dec_state_e;

	////////////////////
	// Bus structs

	// CPU side of a port
	typedef struct packed {
		logic        req;
		logic [15:0] addr;
		logic        we;
		logic [7:0]  wdata;
	} cpu_req_t;

	typedef struct packed {
		logic       ack;
		logic [7:0] rdata;
	} cpu_rsp_t;

	// Bit 15 carries the sub CPU bank
	typedef struct packed {
		logic        ce;
		logic [15:0] addr;
	} rom_req_t;

	typedef struct packed {
		logic         valid;
		vbus_target_e target;
		logic [12:0]  offset;
		logic         we;
		logic [7:0]   wdata;
	} vbus_t;

	typedef struct packed {
		logic         req;
		vbus_target_e target;
		logic [12:0]  offset;
		logic         we;
		logic [7:0]   wdata;
	} shared_req_t;

	typedef struct packed {
		logic       done;
		logic [7:0] rdata;
	} shared_rsp_t;

	// Maps a CPU address onto a video target
	// Sets req only on a hit
	function automatic shared_req_t shared_decode(input logic [15:0] addr, input logic we,
		input logic [7:0] wdata, input logic backcolor_en);
		shared_req_t r;
		r        = '0;
		r.offset = addr[12:0];
		r.we     = we;
		r.wdata  = wdata;
		if (addr[15:13] == SCROLL0_BASE[15:13]) begin
			r.req    = 1'b1;
			r.target = T_SCROLL0;
		end else if (addr[15:13] == SCROLL1_BASE[15:13]) begin
			r.req    = 1'b1;
			r.target = T_SCROLL1;
		end else if (addr[15:13] == OBJECT_BASE[15:13]) begin
			r.req    = 1'b1;
			r.target = T_OBJECT;
		end else if (addr == LATCH0_ADDR) begin
			r.req    = 1'b1;
			r.target = T_LATCH0;
		end else if (addr == LATCH1_ADDR) begin
			r.req    = 1'b1;
			r.target = T_LATCH1;
		end else if (backcolor_en && addr == BACKCOLOR_ADDR) begin
			r.req    = 1'b1;
			r.target = T_BACKCOLOR;
		end
		return r;
	endfunction

endpackage

`default_nettype wire

//--- cpu_subsystem_tb.sv
`default_nettype none
`timescale 1ns/10ps

module cpu_subsystem_tb;

	import cpu_subsystem_pkg::*;

	localparam int   SLOT_CYCLES     = 4;
	localparam int   WATCHDOG_FRAMES = 3;
	localparam int   HS_TIMEOUT      = 8 * SLOT_CYCLES + 10;
	localparam int   NUM_ACCESS      = 21;
	localparam logic CPU_M           = 1'b0;
	localparam logic CPU_S           = 1'b1;

	// One table row
	// on_vbus marks a shared access
	typedef struct packed {
		logic         cpu;
		logic         pair;
		logic [15:0]  addr;
		logic         we;
		logic [7:0]   wdata;
		logic [7:0]   rdata;
		logic         on_vbus;
		vbus_target_e target;
		logic [12:0]  offset;
	} access_t;

	logic       clk_6m;
	logic       rst;
	logic       vblank;
	cpu_req_t   m_cpu;
	cpu_rsp_t   m_rsp;
	rom_req_t   m_rom;
	logic [7:0] m_rom_data = 8'h00;
	cpu_req_t   s_cpu;
	cpu_rsp_t   s_rsp;
	rom_req_t   s_rom;
	logic [7:0] s_rom_data = 8'h00;
	vbus_t      vbus;
	logic [7:0] vbus_rdata = 8'h00;
	logic [7:0] rd_next    = 8'h00;
	logic       m_irq;
	logic       s_irq;
	logic       cpu_reset;

	access_t     tbl [NUM_ACCESS];
	vbus_t       exp_q [$];
	vbus_t       seen [$];
	int          checked_n  = 0;
	logic [15:0] lfsr_state = 16'd41874;

	cpu_subsystem #(
		.SLOT_CYCLES(SLOT_CYCLES),
		.WATCHDOG_FRAMES(WATCHDOG_FRAMES)
	) dut_i (
		.clk_6m(clk_6m), .rst(rst), .vblank(vblank),
		.m_cpu(m_cpu), .m_rsp(m_rsp), .m_rom(m_rom), .m_rom_data(m_rom_data),
		.s_cpu(s_cpu), .s_rsp(s_rsp), .s_rom(s_rom), .s_rom_data(s_rom_data),
		.vbus(vbus), .vbus_rdata(vbus_rdata),
		.m_irq(m_irq), .s_irq(s_irq), .cpu_reset(cpu_reset)
	);

	always #50 clk_6m = ~clk_6m;

	////////////////////
	// ROM and video slave models

	function automatic logic [7:0] rom_byte(input logic [15:0] a);
		return a[7:0] ^ a[15:8];
	endfunction

	always @(posedge clk_6m) begin
		#5;
		if (m_rom.ce)
			m_rom_data = rom_byte(m_rom.addr);
		if (s_rom.ce)
			s_rom_data = rom_byte(s_rom.addr);
		vbus_rdata = rd_next;
	end

	// Strobe is settled by the falling edge
	always @(negedge clk_6m) begin
		if (!rst && vbus.valid) begin
			seen.push_back(vbus);
			if (!vbus.we)
				rd_next = {5'b00000, vbus.target} ^ vbus.offset[7:0];
		end
	end

	////////////////////
	// Checks

	task automatic report_mismatch(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_rsp(input cpu_rsp_t got, input cpu_rsp_t exp, input logic is_read,
		input logic [15:0] addr);
		if (got.ack !== exp.ack || (is_read && got.rdata !== exp.rdata))
			report_mismatch($sformatf("access 0x%04h ack %b data 0x%02h, expected 0x%02h",
				addr, got.ack, got.rdata, exp.rdata));
	endtask

	task automatic check_vbus(input vbus_t got, input vbus_t exp);
		if (got !== exp)
			report_mismatch($sformatf("vbus %0d 0x%04h %b 0x%02h, expected %0d 0x%04h %b 0x%02h",
				got.target, got.offset, got.we, got.wdata,
				exp.target, exp.offset, exp.we, exp.wdata));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	// Every strobe must match one pending access, and none may stay pending
	task automatic match_strobes();
		vbus_t got;
		int    idx;
		while (checked_n < seen.size()) begin
			got = seen[checked_n];
			checked_n++;
			idx = -1;
			foreach (exp_q[k])
				if (idx < 0 && exp_q[k].target == got.target && exp_q[k].offset == got.offset)
					idx = k;
			if (idx < 0)
				report_mismatch($sformatf("unexpected vbus strobe, target %0d offset 0x%04h",
					got.target, got.offset));
			check_vbus(got, exp_q[idx]);
			exp_q.delete(idx);
		end
		if (exp_q.size() != 0)
			abort_run("A shared access finished without its video bus strobe");
	endtask

	////////////////////
	// Stimulus

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic pick_overlap(output logic b);
		b          = lfsr_state[0];
		lfsr_state = lfsr_next(lfsr_state);
	endtask

	function automatic access_t make_access(input logic cpu, input logic pair,
		input logic [15:0] addr, input logic we, input logic [7:0] wdata,
		input logic [7:0] rdata, input logic on_vbus, input vbus_target_e target,
		input logic [12:0] offset);
		access_t a;
		a.cpu     = cpu;
		a.pair    = pair;
		a.addr    = addr;
		a.we      = we;
		a.wdata   = wdata;
		a.rdata   = rdata;
		a.on_vbus = on_vbus;
		a.target  = target;
		a.offset  = offset;
		return a;
	endfunction

	// Full four-phase handshake on one CPU port
	task automatic run_access(input access_t a);
		cpu_req_t req;
		cpu_rsp_t got;
		cpu_rsp_t exp;
		vbus_t    strobe;
		int       n;
		req       = {1'b1, a.addr, a.we, a.wdata};
		exp.ack   = 1'b1;
		exp.rdata = a.rdata;
		if (a.on_vbus) begin
			strobe = {1'b1, a.target, a.offset, a.we, a.wdata};
			exp_q.push_back(strobe);
		end
		@(posedge clk_6m);
		#5;
		if (a.cpu)
			s_cpu = req;
		else
			m_cpu = req;
		n = 0;
		do begin
			@(negedge clk_6m);
			got = a.cpu ? s_rsp : m_rsp;
			n++;
			if (n > HS_TIMEOUT)
				abort_run($sformatf("No ack for CPU %0d access at 0x%04h", a.cpu, a.addr));
		end while (!got.ack);
		check_rsp(got, exp, !a.we, a.addr);
		@(posedge clk_6m);
		#5;
		req.req = 1'b0;
		if (a.cpu)
			s_cpu = req;
		else
			m_cpu = req;
		n = 0;
		do begin
			@(negedge clk_6m);
			got = a.cpu ? s_rsp : m_rsp;
			n++;
			if (n > HS_TIMEOUT)
				abort_run($sformatf("Ack stuck high for CPU %0d at 0x%04h", a.cpu, a.addr));
		end while (got.ack);
	endtask

	task automatic set_vblank(input logic v);
		@(posedge clk_6m);
		#5;
		vblank = v;
	endtask

	task automatic vblank_frame(output int resets);
		resets = 0;
		set_vblank(1'b1);
		repeat (4) begin
			@(negedge clk_6m);
			if (cpu_reset)
				resets++;
		end
		set_vblank(1'b0);
		repeat (4) begin
			@(negedge clk_6m);
			if (cpu_reset)
				resets++;
		end
	endtask

	////////////////////
	// Main sequence

	initial begin
		access_t kick;
		access_t ack_m;
		access_t ack_s;
		int      i;
		int      n;
		int      resets;
		int      total;
		logic    ov;
		clk_6m = 1'b0;
		rst    = 1'b1;
		vblank = 1'b0;
		m_cpu  = '0;
		s_cpu  = '0;
		kick   = make_access(CPU_M, 0, WDOG_ADDR, 1, 8'h00, 8'h00, 0, T_SCROLL0, 13'h0000);
		ack_m  = make_access(CPU_M, 0, IRQACK_ADDR, 1, 8'h00, 8'h00, 0, T_SCROLL0, 13'h0000);
		ack_s  = make_access(CPU_S, 0, IRQACK_ADDR, 1, 8'h00, 8'h00, 0, T_SCROLL0, 13'h0000);

		// cpu, pair, addr, we, wdata, rdata, on_vbus, target, offset
		tbl[0]  = make_access(CPU_M, 1, 16'h8123, 0, 8'h00, 8'h22, 0, T_SCROLL0, 13'h0000);
		tbl[1]  = make_access(CPU_S, 0, 16'h9A5C, 0, 8'h00, 8'h46, 0, T_SCROLL0, 13'h0000);
		tbl[2]  = make_access(CPU_M, 1, 16'h0123, 1, 8'h5A, 8'h00, 1, T_SCROLL0, 13'h0123);
		tbl[3]  = make_access(CPU_S, 0, 16'h2456, 1, 8'hC3, 8'h00, 1, T_SCROLL1, 13'h0456);
		tbl[4]  = make_access(CPU_M, 1, 16'h2034, 0, 8'h00, 8'h35, 1, T_SCROLL1, 13'h0034);
		tbl[5]  = make_access(CPU_S, 0, 16'h4155, 0, 8'h00, 8'h57, 1, T_OBJECT, 13'h0155);
		tbl[6]  = make_access(CPU_M, 1, 16'h6000, 1, 8'h11, 8'h00, 1, T_LATCH0, 13'h0000);
		tbl[7]  = make_access(CPU_S, 0, 16'h6001, 1, 8'h22, 8'h00, 1, T_LATCH1, 13'h0001);
		tbl[8]  = make_access(CPU_M, 1, 16'h6001, 0, 8'h00, 8'h05, 1, T_LATCH1, 13'h0001);
		tbl[9]  = make_access(CPU_S, 0, 16'h6002, 0, 8'h00, 8'h07, 1, T_BACKCOLOR, 13'h0002);
		tbl[10] = make_access(CPU_M, 1, 16'h4ABC, 1, 8'h77, 8'h00, 1, T_OBJECT, 13'h0ABC);
		tbl[11] = make_access(CPU_S, 0, 16'h6002, 1, 8'h3C, 8'h00, 1, T_BACKCOLOR, 13'h0002);
		tbl[12] = make_access(CPU_M, 1, 16'h7400, 0, 8'h00, 8'hFF, 0, T_SCROLL0, 13'h0000);
		tbl[13] = make_access(CPU_S, 0, 16'h7900, 0, 8'h00, 8'hFF, 0, T_SCROLL0, 13'h0000);
		tbl[14] = make_access(CPU_M, 1, 16'h6002, 0, 8'h00, 8'hFF, 0, T_SCROLL0, 13'h0000);
		tbl[15] = make_access(CPU_S, 0, 16'h9000, 1, 8'h99, 8'h00, 0, T_SCROLL0, 13'h0000);
		tbl[16] = make_access(CPU_M, 1, 16'hC000, 1, 8'h55, 8'h00, 0, T_SCROLL0, 13'h0000);
		tbl[17] = make_access(CPU_S, 0, 16'h7000, 1, 8'h01, 8'h00, 0, T_SCROLL0, 13'h0000);
		tbl[18] = make_access(CPU_S, 0, 16'h8123, 0, 8'h00, 8'hA2, 0, T_SCROLL0, 13'h0000);
		tbl[19] = make_access(CPU_S, 0, 16'h0010, 0, 8'h00, 8'h10, 1, T_SCROLL0, 13'h0010);
		tbl[20] = make_access(CPU_M, 0, 16'hFFFF, 0, 8'h00, 8'h80, 0, T_SCROLL0, 13'h0000);

		repeat (3) @(posedge clk_6m);
		#5;
		rst = 1'b0;

		// Paired rows run together or one after the other
		i = 0;
		while (i < NUM_ACCESS) begin
			if (tbl[i].pair) begin
				pick_overlap(ov);
				if (ov) begin
					fork
						run_access(tbl[i]);
						run_access(tbl[i + 1]);
					join
				end else begin
					run_access(tbl[i]);
					run_access(tbl[i + 1]);
				end
				i += 2;
			end else begin
				run_access(tbl[i]);
				i += 1;
			end
			match_strobes();
		end

		// Frame interrupts
		set_vblank(1'b1);
		n = 0;
		do begin
			@(negedge clk_6m);
			n++;
			if (n > HS_TIMEOUT)
				abort_run("m_irq never rose after vblank");
		end while (!m_irq);
		check_bit(s_irq, 1'b1, "s_irq after vblank");
		set_vblank(1'b0);
		run_access(ack_m);
		check_bit(m_irq, 1'b0, "m_irq after master ack");
		check_bit(s_irq, 1'b1, "s_irq after master ack");
		run_access(ack_s);
		check_bit(s_irq, 1'b0, "s_irq after sub ack");

		// Watchdog kicked every frame
		total = 0;
		repeat (4) begin
			run_access(kick);
			vblank_frame(resets);
			total += resets;
		end
		check_bit(total != 0, 1'b0, "cpu_reset with kicks");

		// Watchdog left alone
		run_access(kick);
		vblank_frame(resets);
		total = resets;
		vblank_frame(resets);
		total += resets;
		check_bit(total != 0, 1'b0, "cpu_reset before the watchdog period");
		set_vblank(1'b1);
		n = 0;
		do begin
			@(negedge clk_6m);
			n++;
			if (n > HS_TIMEOUT)
				abort_run("cpu_reset never rose after the watchdog period");
		end while (!cpu_reset);
		repeat (RESET_PULSE - 1) begin
			@(negedge clk_6m);
			check_bit(cpu_reset, 1'b1, "cpu_reset during watchdog pulse");
		end
		@(negedge clk_6m);
		check_bit(cpu_reset, 1'b0, "cpu_reset after watchdog pulse");
		check_bit(s_irq, 1'b0, "s_irq after watchdog reset");
		set_vblank(1'b0);
		match_strobes();

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- master_addr_decoder.sv
`default_nettype none
`timescale 1ns/10ps

module master_addr_decoder #(
	parameter int WATCHDOG_FRAMES = 3
) (
	input  logic                          clk_6m,
	input  logic                          rst,
	input  logic                          frame_start,
	input  cpu_subsystem_pkg::cpu_req_t    cpu,
	output cpu_subsystem_pkg::cpu_rsp_t    rsp,
	output cpu_subsystem_pkg::rom_req_t    rom,
	input  logic [7:0]                    rom_data,
	output cpu_subsystem_pkg::shared_req_t sh_req,
	input  cpu_subsystem_pkg::shared_rsp_t sh_rsp,
	output logic                          irq,
	output logic                          wdog_reset
);

	import cpu_subsystem_pkg::*;

	localparam int FRAME_W = $clog2(WATCHDOG_FRAMES + 1);
	localparam int PULSE_W = $clog2(RESET_PULSE + 1);

	dec_state_e       state;
	shared_req_t      sh_next;
	logic             accept;
	logic             wdog_kick;
	logic             irq_ack;
	logic [FRAME_W-1:0] frames;
	logic [PULSE_W-1:0] pulse_cnt;

	always_comb begin
		accept    = (state == S_IDLE) && cpu.req;
		sh_next   = shared_decode(cpu.addr, cpu.we, cpu.wdata, 1'b0);
		wdog_kick = accept && cpu.we && (cpu.addr == WDOG_ADDR);
		irq_ack   = accept && cpu.we && (cpu.addr == IRQACK_ADDR);
	end

	////////////////////
	// Access FSM

	always_ff @(posedge clk_6m) begin
		if (rst) begin
			state      <= S_IDLE;
			rsp.ack    <= 1'b0;
			rom.ce     <= 1'b0;
			sh_req.req <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (cpu.req) begin
						rsp.rdata <= UNMAPPED_DATA;
						if (cpu.addr >= ROM_BASE) begin
							// ROM writes are dropped
							if (cpu.we) begin
								state <= S_ACK;
							end else begin
								rom.ce   <= 1'b1;
								rom.addr <= {1'b0, cpu.addr[14:0]};
								state    <= S_ROM;
							end
						end else if (sh_next.req) begin
							sh_req <= sh_next;
							state  <= S_SHARED;
						end else begin
							state <= S_ACK;
						end
					end
				end
				S_ROM: begin
					rsp.rdata <= rom_data;
					rom.ce    <= 1'b0;
					state     <= S_ACK;
				end
				S_SHARED: begin
					if (sh_rsp.done) begin
						sh_req.req <= 1'b0;
						rsp.rdata  <= sh_rsp.rdata;
						rsp.ack    <= 1'b1;
						state      <= S_ACK;
					end
				end
				S_ACK: begin
					// Hold ack until the CPU lets go
					rsp.ack <= 1'b1;
					if (rsp.ack && !cpu.req) begin
						rsp.ack <= 1'b0;
						state   <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	////////////////////
	// Irq and watchdog

	always_ff @(posedge clk_6m) begin
		if (rst) begin
			irq <= 1'b0;
		end else if (frame_start) begin
			irq <= 1'b1;
		end else if (irq_ack || wdog_reset) begin
			irq <= 1'b0;
		end
	end

	always_ff @(posedge clk_6m) begin
		if (rst) begin
			frames    <= '0;
			pulse_cnt <= '0;
		end else begin
			if (pulse_cnt != '0)
				pulse_cnt <= pulse_cnt - 1'b1;
			if (wdog_kick) begin
				frames <= '0;
			end else if (frame_start) begin
				if (frames == FRAME_W'(WATCHDOG_FRAMES - 1)) begin
					frames    <= '0;
					pulse_cnt <= PULSE_W'(RESET_PULSE);
				end else begin
					frames <= frames + 1'b1;
				end
			end
		end
	end

	assign wdog_reset = (pulse_cnt != '0);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -f all.f --top-module cpu_subsystem_tb

# The run itself may stop early, the verdict comes from its output
out=$(./obj_dir/Vcpu_subsystem_tb || true)
echo "$out"
echo "$out" | grep -q "^TEST PASS$"

//--- shared_bus_mux.sv
`default_nettype none
`timescale 1ns/10ps

module shared_bus_mux (
	input  logic                          clk_6m,
	input  logic                          rst,
	input  logic                          slot_master,
	input  logic                          slot_start,
	input  cpu_subsystem_pkg::shared_req_t m_req,
	output cpu_subsystem_pkg::shared_rsp_t m_rsp,
	input  cpu_subsystem_pkg::shared_req_t s_req,
	output cpu_subsystem_pkg::shared_rsp_t s_rsp,
	output cpu_subsystem_pkg::vbus_t       vbus,
	input  logic [7:0]                    vbus_rdata
);

	import cpu_subsystem_pkg::*;

	shared_req_t sel;
	logic        m_go;
	logic        s_go;
	logic        m_issued;
	logic        s_issued;
	logic        done_stb;
	logic        last_master;

	////////////////////
	// Slot arbitration

	// Strobe lands in the first cycle of the owner's slot
	always_comb begin
		m_go = slot_start && slot_master && m_req.req && !m_issued;
		s_go = slot_start && !slot_master && s_req.req && !s_issued;
		sel  = slot_master ? m_req : s_req;

		vbus.valid  = m_go || s_go;
		vbus.target = sel.target;
		vbus.offset = sel.offset;
		vbus.we     = sel.we;
		vbus.wdata  = sel.wdata;
	end

	always_ff @(posedge clk_6m) begin
		if (rst) begin
			m_issued    <= 1'b0;
			s_issued    <= 1'b0;
			done_stb    <= 1'b0;
			last_master <= 1'b0;
		end else begin
			done_stb <= vbus.valid;
			if (vbus.valid)
				last_master <= slot_master;

			// Issued flag holds until the decoder drops req
			if (m_go)
				m_issued <= 1'b1;
			else if (!m_req.req)
				m_issued <= 1'b0;

			if (s_go)
				s_issued <= 1'b1;
			else if (!s_req.req)
				s_issued <= 1'b0;
		end
	end

	////////////////////
	// Completion

	// Slave data is valid in the cycle after the strobe
	always_comb begin
		m_rsp.done  = done_stb && last_master;
		m_rsp.rdata = vbus_rdata;
		s_rsp.done  = done_stb && !last_master;
		s_rsp.rdata = vbus_rdata;
	end

endmodule

`default_nettype wire

//--- sub_addr_decoder.sv
`default_nettype none
`timescale 1ns/10ps

module sub_addr_decoder (
	input  logic                          clk_6m,
	input  logic                          rst,
	input  logic                          cpu_reset,
	input  logic                          frame_start,
	input  cpu_subsystem_pkg::cpu_req_t    cpu,
	output cpu_subsystem_pkg::cpu_rsp_t    rsp,
	output cpu_subsystem_pkg::rom_req_t    rom,
	input  logic [7:0]                    rom_data,
	output cpu_subsystem_pkg::shared_req_t sh_req,
	input  cpu_subsystem_pkg::shared_rsp_t sh_rsp,
	output logic                          irq
);

	import cpu_subsystem_pkg::*;

	dec_state_e  state;
	shared_req_t sh_next;
	logic        accept;
	logic        bank_wr;
	logic        irq_ack;
	logic        bank;

	// Sub CPU also reaches backcolor
	always_comb begin
		accept  = (state == S_IDLE) && cpu.req;
		sh_next = shared_decode(cpu.addr, cpu.we, cpu.wdata, 1'b1);
		bank_wr = accept && cpu.we && (cpu.addr == BANK_ADDR);
		irq_ack = accept && cpu.we && (cpu.addr == IRQACK_ADDR);
	end

	////////////////////
	// Access FSM

	always_ff @(posedge clk_6m) begin
		if (rst) begin
			state      <= S_IDLE;
			rsp.ack    <= 1'b0;
			rom.ce     <= 1'b0;
			sh_req.req <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (cpu.req) begin
						rsp.rdata <= UNMAPPED_DATA;
						if (cpu.addr >= ROM_BASE) begin
							if (cpu.we) begin
								state <= S_ACK;
							end else begin
								// Bank picks the upper half of the ROM
								rom.ce   <= 1'b1;
								rom.addr <= {bank, cpu.addr[14:0]};
								state    <= S_ROM;
							end
						end else if (sh_next.req) begin
							sh_req <= sh_next;
							state  <= S_SHARED;
						end else begin
							state <= S_ACK;
						end
					end
				end
				S_ROM: begin
					rsp.rdata <= rom_data;
					rom.ce    <= 1'b0;
					state     <= S_ACK;
				end
				S_SHARED: begin
					if (sh_rsp.done) begin
						sh_req.req <= 1'b0;
						rsp.rdata  <= sh_rsp.rdata;
						rsp.ack    <= 1'b1;
						state      <= S_ACK;
					end
				end
				S_ACK: begin
					rsp.ack <= 1'b1;
					if (rsp.ack && !cpu.req) begin
						rsp.ack <= 1'b0;
						state   <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	////////////////////
	// Local registers

	// Both follow the CPU reset line
	always_ff @(posedge clk_6m) begin
		if (rst || cpu_reset) begin
			irq  <= 1'b0;
			bank <= 1'b0;
		end else begin
			if (frame_start)
				irq <= 1'b1;
			else if (irq_ack)
				irq <= 1'b0;
			if (bank_wr)
				bank <= cpu.wdata[0];
		end
	end

endmodule

`default_nettype wire
